//--- mesh_cluster.f
+incdir+include
hdl/mesh_cluster_pkg.sv
hdl/mesh_input_port.sv
hdl/mesh_rr_arbiter.sv
hdl/mesh_router.sv
hdl/mesh_cluster.sv
test/mesh_cluster_properties.sv
test/mesh_cluster_tb.sv

//--- Makefile
# Verilator flow for the mesh cluster

VERILATOR  ?= verilator
FLIST      ?= mesh_cluster.f
TB_TOP     ?= mesh_cluster_tb
RTL_TOP    ?= mesh_cluster
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
RUN_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- test/mesh_cluster_tb.sv
// Mesh cluster testbench
// Random local and edge traffic, scoreboard per destination and final report

`include "mesh_cluster_settings.svh"

module mesh_cluster_tb;

  localparam int NUM_GROUPS     = `MESH_X * `MESH_Y;
  localparam int NUM_EDGES      = 2 * `MESH_Y;
  localparam int NUM_SRC        = NUM_GROUPS + NUM_EDGES;
  localparam int NUM_DEST       = NUM_GROUPS + NUM_EDGES;
  localparam int PER_SRC        = 50;
  localparam int TOTAL_FLITS    = NUM_SRC * PER_SRC;
  localparam int TIMEOUT_CYCLES = TOTAL_FLITS * 50;
  localparam int DRAIN_CYCLES   = 20;

  logic                                    clk_i;
  logic                                    rst_n_i;
  mesh_cluster_pkg::flit_t [NUM_GROUPS-1:0] local_in_i;
  logic                    [NUM_GROUPS-1:0] local_in_valid_i;
  logic                    [NUM_GROUPS-1:0] local_in_ready_o;
  mesh_cluster_pkg::flit_t [NUM_GROUPS-1:0] local_out_o;
  logic                    [NUM_GROUPS-1:0] local_out_valid_o;
  logic                    [NUM_GROUPS-1:0] local_out_ready_i;
  mesh_cluster_pkg::flit_t [NUM_EDGES-1:0]  edge_in_i;
  logic                    [NUM_EDGES-1:0]  edge_in_valid_i;
  logic                    [NUM_EDGES-1:0]  edge_in_ready_o;
  mesh_cluster_pkg::flit_t [NUM_EDGES-1:0]  edge_out_o;
  logic                    [NUM_EDGES-1:0]  edge_out_valid_o;
  logic                    [NUM_EDGES-1:0]  edge_out_ready_i;

  // Sources 0 to NUM_GROUPS-1 are locals, the rest are edge inputs
  mesh_cluster_pkg::flit_t src_flit [NUM_SRC];
  logic                    src_valid [NUM_SRC];
  logic                    src_taken [NUM_SRC];
  int                      src_sent [NUM_SRC];
  logic [7:0]              seq_num [NUM_SRC][NUM_DEST];
  mesh_cluster_pkg::flit_t exp_q [$];
  logic [31:0]             rng;
  int                      cycle_cnt;
  int                      injected;
  int                      delivered;
  int                      sb_errors;
  int                      timeouts;
  int                      assert_fails;

  mesh_cluster mesh_cluster_inst (
    .clk_i            (clk_i            ),
    .rst_n_i          (rst_n_i          ),
    .local_in_i       (local_in_i       ),
    .local_in_valid_i (local_in_valid_i ),
    .local_in_ready_o (local_in_ready_o ),
    .local_out_o      (local_out_o      ),
    .local_out_valid_o(local_out_valid_o),
    .local_out_ready_i(local_out_ready_i),
    .edge_in_i        (edge_in_i        ),
    .edge_in_valid_i  (edge_in_valid_i  ),
    .edge_in_ready_o  (edge_in_ready_o  ),
    .edge_out_o       (edge_out_o       ),
    .edge_out_valid_o (edge_out_valid_o ),
    .edge_out_ready_i (edge_out_ready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Edge sources only target groups, local sources target groups or edges
  task automatic new_flit(input int s);
    mesh_cluster_pkg::flit_t f;
    int                      dkey;
    f   = '0;
    rng = xorshift(rng);
    f.src_id = `GROUP_ID_W'(s < NUM_GROUPS ? s : s - NUM_GROUPS);
    if (s >= NUM_GROUPS || rng[0]) begin
      dkey = int'(rng[15:8]) % NUM_GROUPS;
      f.dest.node.x = `COORD_W'(dkey / `MESH_Y);
      f.dest.node.y = `COORD_W'(dkey % `MESH_Y);
    end else begin
      dkey = NUM_GROUPS + int'(rng[15:8]) % NUM_EDGES;
      f.is_edge = 1'b1;
      f.dest.edge_port.side = `COORD_W'((dkey - NUM_GROUPS) / `MESH_Y);
      f.dest.edge_port.row  = `COORD_W'((dkey - NUM_GROUPS) % `MESH_Y);
    end
    // Source kind on top, sequence number in the low byte
    f.payload = `PAYLOAD_W'({s >= NUM_GROUPS, rng[22:16], seq_num[s][dkey]});
    seq_num[s][dkey] = seq_num[s][dkey] + 8'd1;
    src_flit[s] = f;
  endtask

  task automatic drive_inputs();
    for (int s = 0; s < NUM_SRC; s++) begin
      if (src_taken[s]) begin
        src_valid[s] = 1'b0;
        src_taken[s] = 1'b0;
      end
      rng = xorshift(rng);
      if (!src_valid[s] && src_sent[s] < PER_SRC && rng[1:0] != 2'd0) begin
        new_flit(s);
        src_valid[s] = 1'b1;
        src_sent[s]++;
      end
    end
    for (int g = 0; g < NUM_GROUPS; g++) begin
      local_in_i[g]       = src_flit[g];
      local_in_valid_i[g] = src_valid[g];
      rng = xorshift(rng);
      local_out_ready_i[g] = (rng[2:0] != 3'd0);
    end
    for (int e = 0; e < NUM_EDGES; e++) begin
      edge_in_i[e]       = src_flit[NUM_GROUPS + e];
      edge_in_valid_i[e] = src_valid[NUM_GROUPS + e];
      rng = xorshift(rng);
      edge_out_ready_i[e] = (rng[2:0] != 3'd0);
    end
  endtask

  // Oldest queued flit with the same source and destination must match
  task automatic check_delivery(input mesh_cluster_pkg::flit_t f, input string port,
                                input int idx);
    int hit;
    hit = -1;
    delivered++;
    for (int i = 0; i < exp_q.size() && hit < 0; i++) begin
      if (exp_q[i].is_edge == f.is_edge && exp_q[i].dest == f.dest &&
          exp_q[i].src_id == f.src_id &&
          exp_q[i].payload[`PAYLOAD_W-1] == f.payload[`PAYLOAD_W-1]) begin
        hit = i;
      end
    end
    if (hit < 0) begin
      sb_errors++;
      $display("[FAIL] %s[%0d] = 0x%h matches no injected flit", port, idx, f);
    end else begin
      if (exp_q[hit].payload != f.payload) begin
        sb_errors++;
        $display("[FAIL] %s[%0d].payload = 0x%h, expected 0x%h",
                 port, idx, f.payload, exp_q[hit].payload);
      end
      exp_q.delete(hit);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (rst_n_i) begin
      for (int g = 0; g < NUM_GROUPS; g++) begin
        if (local_in_valid_i[g] && local_in_ready_o[g]) begin
          exp_q.push_back(local_in_i[g]);
          src_taken[g] = 1'b1;
          injected++;
        end
      end
      for (int e = 0; e < NUM_EDGES; e++) begin
        if (edge_in_valid_i[e] && edge_in_ready_o[e]) begin
          exp_q.push_back(edge_in_i[e]);
          src_taken[NUM_GROUPS + e] = 1'b1;
          injected++;
        end
      end
      for (int g = 0; g < NUM_GROUPS; g++) begin
        if (local_out_valid_o[g] && local_out_ready_i[g]) begin
          check_delivery(local_out_o[g], "local_out_o", g);
        end
      end
      for (int e = 0; e < NUM_EDGES; e++) begin
        if (edge_out_valid_o[e] && edge_out_ready_i[e]) begin
          check_delivery(edge_out_o[e], "edge_out_o", e);
        end
      end
    end
  end

  initial begin
    rng               = 32'd28;
    cycle_cnt         = 0;
    injected          = 0;
    delivered         = 0;
    sb_errors         = 0;
    timeouts          = 0;
    rst_n_i           = 1'b0;
    local_in_i        = '0;
    local_in_valid_i  = '0;
    local_out_ready_i = '1;
    edge_in_i         = '0;
    edge_in_valid_i   = '0;
    edge_out_ready_i  = '1;
    for (int s = 0; s < NUM_SRC; s++) begin
      src_flit[s]  = '0;
      src_valid[s] = 1'b0;
      src_taken[s] = 1'b0;
      src_sent[s]  = 0;
      for (int d = 0; d < NUM_DEST; d++) begin
        seq_num[s][d] = 8'd0;
      end
    end
    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b1;

    while (delivered < TOTAL_FLITS && cycle_cnt < TIMEOUT_CYCLES) begin
      drive_inputs();
      @(negedge clk_i);
    end

    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      timeouts = 1;
      $display("Timeout after %0d cycles with %0d of %0d flits delivered",
               cycle_cnt, delivered, TOTAL_FLITS);
    end

    // Quiet window catches late duplicates
    local_in_valid_i  = '0;
    edge_in_valid_i   = '0;
    local_out_ready_i = '1;
    edge_out_ready_i  = '1;
    repeat (DRAIN_CYCLES) @(negedge clk_i);

    if (exp_q.size() != 0) begin
      sb_errors++;
      $display("%0d injected flits never arrived at an output", exp_q.size());
    end
    assert_fails = int'(mesh_cluster_inst.props_inst.fail_cnt);
    $display("Injected %0d, delivered %0d, errors %0d, assertion failures %0d, timeouts %0d",
             injected, delivered, sb_errors, assert_fails, timeouts);
    if (sb_errors + assert_fails + timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- test/mesh_cluster_properties.sv
// Mesh cluster output checks, bound to the top level
// Reset state, delivery port per destination and hold under back-pressure

`include "mesh_cluster_settings.svh"

module mesh_cluster_properties (
  input logic                                             clk_i,
  input logic                                             rst_n_i,
  input mesh_cluster_pkg::flit_t [`MESH_X*`MESH_Y-1:0]    local_out_o,
  input logic                    [`MESH_X*`MESH_Y-1:0]    local_out_valid_o,
  input logic                    [`MESH_X*`MESH_Y-1:0]    local_out_ready_i,
  input mesh_cluster_pkg::flit_t [2*`MESH_Y-1:0]          edge_out_o,
  input logic                    [2*`MESH_Y-1:0]          edge_out_valid_o,
  input logic                    [2*`MESH_Y-1:0]          edge_out_ready_i
);

  int unsigned fail_cnt = 0;

  for (genvar g = 0; g < `MESH_X * `MESH_Y; g++) begin : gen_local
    local_reset_idle: assert property (@(posedge clk_i) !rst_n_i |=> !local_out_valid_o[g])
      else begin
        fail_cnt++;
        $error("local_out_valid_o[%0d] high after reset", g);
      end

    // Group index is x times the row count plus y
    local_dest: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      local_out_valid_o[g] |-> !local_out_o[g].is_edge &&
        int'(local_out_o[g].dest.node.x) * `MESH_Y + int'(local_out_o[g].dest.node.y) == g)
      else begin
        fail_cnt++;
        $error("local_out_o[%0d] carries flit 0x%h for another port", g, local_out_o[g]);
      end

    local_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      local_out_valid_o[g] && !local_out_ready_i[g] |=>
        local_out_valid_o[g] && $stable(local_out_o[g]))
      else begin
        fail_cnt++;
        $error("local_out_o[%0d] changed while stalled", g);
      end
  end : gen_local

  for (genvar e = 0; e < 2 * `MESH_Y; e++) begin : gen_edge
    edge_reset_idle: assert property (@(posedge clk_i) !rst_n_i |=> !edge_out_valid_o[e])
      else begin
        fail_cnt++;
        $error("edge_out_valid_o[%0d] high after reset", e);
      end

    // West rows first, east rows after them
    edge_dest: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      edge_out_valid_o[e] |-> edge_out_o[e].is_edge &&
        (edge_out_o[e].dest.edge_port.side[0] ? `MESH_Y : 0) +
        int'(edge_out_o[e].dest.edge_port.row) == e)
      else begin
        fail_cnt++;
        $error("edge_out_o[%0d] carries flit 0x%h for another port", e, edge_out_o[e]);
      end

    edge_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      edge_out_valid_o[e] && !edge_out_ready_i[e] |=>
        edge_out_valid_o[e] && $stable(edge_out_o[e]))
      else begin
        fail_cnt++;
        $error("edge_out_o[%0d] changed while stalled", e);
      end
  end : gen_edge

endmodule

bind mesh_cluster mesh_cluster_properties props_inst (
  .clk_i            (clk_i            ),
  .rst_n_i          (rst_n_i          ),
  .local_out_o      (local_out_o      ),
  .local_out_valid_o(local_out_valid_o),
  .local_out_ready_i(local_out_ready_i),
  .edge_out_o       (edge_out_o       ),
  .edge_out_valid_o (edge_out_valid_o ),
  .edge_out_ready_i (edge_out_ready_i )
);

//--- hdl/mesh_cluster.sv
// Mesh cluster top level
// Places group routers in a 2D mesh and maps locals and side edges to ports

`include "mesh_cluster_settings.svh"

module mesh_cluster #(
  parameter int unsigned NUM_GROUPS = `MESH_X * `MESH_Y,
  parameter int unsigned NUM_EDGES  = 2 * `MESH_Y
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // Local group ports
  input  mesh_cluster_pkg::flit_t [NUM_GROUPS-1:0] local_in_i,
  input  logic                    [NUM_GROUPS-1:0] local_in_valid_i,
  output logic                    [NUM_GROUPS-1:0] local_in_ready_o,
  output mesh_cluster_pkg::flit_t [NUM_GROUPS-1:0] local_out_o,
  output logic                    [NUM_GROUPS-1:0] local_out_valid_o,
  input  logic                    [NUM_GROUPS-1:0] local_out_ready_i,
  // West edges first, then east
  input  mesh_cluster_pkg::flit_t [NUM_EDGES-1:0]  edge_in_i,
  input  logic                    [NUM_EDGES-1:0]  edge_in_valid_i,
  output logic                    [NUM_EDGES-1:0]  edge_in_ready_o,
  output mesh_cluster_pkg::flit_t [NUM_EDGES-1:0]  edge_out_o,
  output logic                    [NUM_EDGES-1:0]  edge_out_valid_o,
  input  logic                    [NUM_EDGES-1:0]  edge_out_ready_i
);

  mesh_cluster_pkg::flit_t [`MESH_X-1:0][`MESH_Y-1:0][`NUM_PORTS-1:0] rin_flit, rout_flit;
  logic [`MESH_X-1:0][`MESH_Y-1:0][`NUM_PORTS-1:0] rin_valid, rin_ready;
  logic [`MESH_X-1:0][`MESH_Y-1:0][`NUM_PORTS-1:0] rout_valid, rout_ready;

  for (genvar x = 0; x < `MESH_X; x++) begin : gen_x
    for (genvar y = 0; y < `MESH_Y; y++) begin : gen_y
      localparam int unsigned GID = x * `MESH_Y + y;

      assign rin_flit[x][y][mesh_cluster_pkg::DIR_LOCAL]   = local_in_i[GID];
      assign rin_valid[x][y][mesh_cluster_pkg::DIR_LOCAL]  = local_in_valid_i[GID];
      assign local_in_ready_o[GID]  = rin_ready[x][y][mesh_cluster_pkg::DIR_LOCAL];
      assign local_out_o[GID]       = rout_flit[x][y][mesh_cluster_pkg::DIR_LOCAL];
      assign local_out_valid_o[GID] = rout_valid[x][y][mesh_cluster_pkg::DIR_LOCAL];
      assign rout_ready[x][y][mesh_cluster_pkg::DIR_LOCAL] = local_out_ready_i[GID];

      if (x == 0) begin : gen_west_edge
        assign rin_flit[x][y][mesh_cluster_pkg::DIR_WEST]   = edge_in_i[y];
        assign rin_valid[x][y][mesh_cluster_pkg::DIR_WEST]  = edge_in_valid_i[y];
        assign edge_in_ready_o[y]  = rin_ready[x][y][mesh_cluster_pkg::DIR_WEST];
        assign edge_out_o[y]       = rout_flit[x][y][mesh_cluster_pkg::DIR_WEST];
        assign edge_out_valid_o[y] = rout_valid[x][y][mesh_cluster_pkg::DIR_WEST];
        assign rout_ready[x][y][mesh_cluster_pkg::DIR_WEST] = edge_out_ready_i[y];
      end else begin : gen_west_link
        assign rin_flit[x][y][mesh_cluster_pkg::DIR_WEST]   =
            rout_flit[x-1][y][mesh_cluster_pkg::DIR_EAST];
        assign rin_valid[x][y][mesh_cluster_pkg::DIR_WEST]  =
            rout_valid[x-1][y][mesh_cluster_pkg::DIR_EAST];
        assign rout_ready[x][y][mesh_cluster_pkg::DIR_WEST] =
            rin_ready[x-1][y][mesh_cluster_pkg::DIR_EAST];
      end

      if (x == `MESH_X - 1) begin : gen_east_edge
        assign rin_flit[x][y][mesh_cluster_pkg::DIR_EAST]   = edge_in_i[`MESH_Y + y];
        assign rin_valid[x][y][mesh_cluster_pkg::DIR_EAST]  = edge_in_valid_i[`MESH_Y + y];
        assign edge_in_ready_o[`MESH_Y + y]  = rin_ready[x][y][mesh_cluster_pkg::DIR_EAST];
        assign edge_out_o[`MESH_Y + y]       = rout_flit[x][y][mesh_cluster_pkg::DIR_EAST];
        assign edge_out_valid_o[`MESH_Y + y] = rout_valid[x][y][mesh_cluster_pkg::DIR_EAST];
        assign rout_ready[x][y][mesh_cluster_pkg::DIR_EAST] = edge_out_ready_i[`MESH_Y + y];
      end else begin : gen_east_link
        assign rin_flit[x][y][mesh_cluster_pkg::DIR_EAST]   =
            rout_flit[x+1][y][mesh_cluster_pkg::DIR_WEST];
        assign rin_valid[x][y][mesh_cluster_pkg::DIR_EAST]  =
            rout_valid[x+1][y][mesh_cluster_pkg::DIR_WEST];
        assign rout_ready[x][y][mesh_cluster_pkg::DIR_EAST] =
            rin_ready[x+1][y][mesh_cluster_pkg::DIR_WEST];
      end

      // Top and bottom rows have no neighbour in that direction
      if (y == `MESH_Y - 1) begin : gen_north_tie
        assign rin_flit[x][y][mesh_cluster_pkg::DIR_NORTH]   = '0;
        assign rin_valid[x][y][mesh_cluster_pkg::DIR_NORTH]  = 1'b0;
        assign rout_ready[x][y][mesh_cluster_pkg::DIR_NORTH] = 1'b1;
      end else begin : gen_north_link
        assign rin_flit[x][y][mesh_cluster_pkg::DIR_NORTH]   =
            rout_flit[x][y+1][mesh_cluster_pkg::DIR_SOUTH];
        assign rin_valid[x][y][mesh_cluster_pkg::DIR_NORTH]  =
            rout_valid[x][y+1][mesh_cluster_pkg::DIR_SOUTH];
        assign rout_ready[x][y][mesh_cluster_pkg::DIR_NORTH] =
            rin_ready[x][y+1][mesh_cluster_pkg::DIR_SOUTH];
      end

      if (y == 0) begin : gen_south_tie
        assign rin_flit[x][y][mesh_cluster_pkg::DIR_SOUTH]   = '0;
        assign rin_valid[x][y][mesh_cluster_pkg::DIR_SOUTH]  = 1'b0;
        assign rout_ready[x][y][mesh_cluster_pkg::DIR_SOUTH] = 1'b1;
      end else begin : gen_south_link
        assign rin_flit[x][y][mesh_cluster_pkg::DIR_SOUTH]   =
            rout_flit[x][y-1][mesh_cluster_pkg::DIR_NORTH];
        assign rin_valid[x][y][mesh_cluster_pkg::DIR_SOUTH]  =
            rout_valid[x][y-1][mesh_cluster_pkg::DIR_NORTH];
        assign rout_ready[x][y][mesh_cluster_pkg::DIR_SOUTH] =
            rin_ready[x][y-1][mesh_cluster_pkg::DIR_NORTH];
      end

      mesh_router #(
        .NODE_X(x),
        .NODE_Y(y)
      ) i_router (
        .clk_i      (clk_i           ),
        .rst_n_i    (rst_n_i         ),
        .in_flit_i  (rin_flit[x][y]  ),
        .in_valid_i (rin_valid[x][y] ),
        .in_ready_o (rin_ready[x][y] ),
        .out_flit_o (rout_flit[x][y] ),
        .out_valid_o(rout_valid[x][y]),
        .out_ready_i(rout_ready[x][y])
      );
    end : gen_y
  end : gen_x

endmodule

//--- hdl/mesh_router.sv
// Five-port group router
// Input buffers, per-output round-robin arbitration and output registers

`include "mesh_cluster_settings.svh"

module mesh_router #(
  parameter int unsigned NODE_X = 0,
  parameter int unsigned NODE_Y = 0
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  mesh_cluster_pkg::flit_t [`NUM_PORTS-1:0]      in_flit_i,
  input  logic                    [`NUM_PORTS-1:0]      in_valid_i,
  output logic                    [`NUM_PORTS-1:0]      in_ready_o,
  output mesh_cluster_pkg::flit_t [`NUM_PORTS-1:0]      out_flit_o,
  output logic                    [`NUM_PORTS-1:0]      out_valid_o,
  input  logic                    [`NUM_PORTS-1:0]      out_ready_i
);

  localparam logic [`COORD_W-1:0] X_COORD = NODE_X[`COORD_W-1:0];
  localparam logic [`COORD_W-1:0] Y_COORD = NODE_Y[`COORD_W-1:0];

  mesh_cluster_pkg::flit_t [`NUM_PORTS-1:0]                  head_flit;
  logic                    [`NUM_PORTS-1:0][`NUM_PORTS-1:0]  head_req;
  logic                    [`NUM_PORTS-1:0]                  head_pop;
  // Indexed [output][input]
  logic                    [`NUM_PORTS-1:0][`NUM_PORTS-1:0]  out_req;
  logic                    [`NUM_PORTS-1:0][`NUM_PORTS-1:0]  gnt;
  mesh_cluster_pkg::flit_t [`NUM_PORTS-1:0]                  sel_flit;
  logic                    [`NUM_PORTS-1:0]                  load;
  mesh_cluster_pkg::flit_t [`NUM_PORTS-1:0]                  out_flit_q;
  logic                    [`NUM_PORTS-1:0]                  out_valid_q;

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : gen_inputs
    mesh_input_port i_input_port (
      .clk_i      (clk_i        ),
      .rst_n_i    (rst_n_i      ),
      .in_flit_i  (in_flit_i[p] ),
      .in_valid_i (in_valid_i[p]),
      .in_ready_o (in_ready_o[p]),
      .head_flit_o(head_flit[p] ),
      .head_req_o (head_req[p]  ),
      .head_pop_i (head_pop[p]  ),
      .node_x_i   (X_COORD      ),
      .node_y_i   (Y_COORD      )
    );
  end : gen_inputs

  always_comb begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      for (int p = 0; p < `NUM_PORTS; p++) begin
        out_req[o][p] = head_req[p][o];
      end
    end
  end

  for (genvar o = 0; o < `NUM_PORTS; o++) begin : gen_outputs
    mesh_rr_arbiter i_arbiter (
      .clk_i    (clk_i     ),
      .rst_n_i  (rst_n_i   ),
      .req_i    (out_req[o]),
      .gnt_o    (gnt[o]    ),
      .advance_i(load[o]   )
    );

    // Register is free when empty or drained this cycle
    assign load[o] = (|gnt[o]) && (!out_valid_q[o] || out_ready_i[o]);

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        out_valid_q[o] <= 1'b0;
      end else if (load[o]) begin
        out_valid_q[o] <= 1'b1;
      end else if (out_ready_i[o]) begin
        out_valid_q[o] <= 1'b0;
      end
    end

    always_ff @(posedge clk_i) begin
      if (load[o]) begin
        out_flit_q[o] <= sel_flit[o];
      end
    end
  end : gen_outputs

  // Grants are one-hot, so a plain select is enough
  always_comb begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      sel_flit[o] = '0;
      for (int p = 0; p < `NUM_PORTS; p++) begin
        if (gnt[o][p]) begin
          sel_flit[o] = head_flit[p];
        end
      end
    end
  end

  // Each input requests a single output, so at most one load pops it
  always_comb begin
    for (int p = 0; p < `NUM_PORTS; p++) begin
      head_pop[p] = 1'b0;
      for (int o = 0; o < `NUM_PORTS; o++) begin
        head_pop[p] = head_pop[p] | (load[o] & gnt[o][p]);
      end
    end
  end

  assign out_flit_o  = out_flit_q;
  assign out_valid_o = out_valid_q;

endmodule

//--- hdl/mesh_rr_arbiter.sv
// Round-robin arbiter for one router output
// Grants the first requester at or after the pointer

`include "mesh_cluster_settings.svh"

module mesh_rr_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`NUM_PORTS-1:0] req_i,
  output logic [`NUM_PORTS-1:0] gnt_o,
  input  logic                  advance_i
);

  localparam int unsigned IDX_W = $clog2(`NUM_PORTS);

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] win_idx;
  logic             found;

  always_comb begin
    int unsigned idx;
    gnt_o   = '0;
    win_idx = ptr_q;
    found   = 1'b0;
    for (int unsigned i = 0; i < `NUM_PORTS; i++) begin
      idx = (int'(ptr_q) + i) % `NUM_PORTS;
      if (!found && req_i[idx]) begin
        found      = 1'b1;
        gnt_o[idx] = 1'b1;
        win_idx    = IDX_W'(idx);
      end
    end
  end

  // Step past the winner once its flit is taken
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (advance_i && found) begin
      if (win_idx == IDX_W'(`NUM_PORTS - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= win_idx + 1'b1;
      end
    end
  end

endmodule

//--- hdl/mesh_input_port.sv
// Router input port
// Two-entry flit buffer with Y-then-X route choice for the head flit

`include "mesh_cluster_settings.svh"

module mesh_input_port (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  mesh_cluster_pkg::flit_t in_flit_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output mesh_cluster_pkg::flit_t head_flit_o,
  output logic [`NUM_PORTS-1:0]   head_req_o,
  input  logic                    head_pop_i,
  input  logic [`COORD_W-1:0]     node_x_i,
  input  logic [`COORD_W-1:0]     node_y_i
);

  mesh_cluster_pkg::flit_t buf_q [2];
  logic                    wr_ptr_q;
  logic                    rd_ptr_q;
  logic [1:0]              count_q;
  logic                    push;
  logic                    pop;
  logic [`COORD_W-1:0]     dest_row;
  mesh_cluster_pkg::dir_e  route_dir;

  assign in_ready_o  = (count_q != 2'd2);
  assign push        = in_valid_i && in_ready_o;
  assign pop         = head_pop_i && (count_q != 2'd0);
  assign head_flit_o = buf_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= in_flit_i;
    end
  end

  // Row first, then column or edge side
  always_comb begin
    // Row and y occupy the same bits in both views
    dest_row = head_flit_o.dest.node.y;
    if (dest_row > node_y_i) begin
      route_dir = mesh_cluster_pkg::DIR_NORTH;
    end else if (dest_row < node_y_i) begin
      route_dir = mesh_cluster_pkg::DIR_SOUTH;
    end else if (head_flit_o.is_edge) begin
      route_dir = head_flit_o.dest.edge_port.side[0] ? mesh_cluster_pkg::DIR_EAST
                                                     : mesh_cluster_pkg::DIR_WEST;
    end else if (head_flit_o.dest.node.x > node_x_i) begin
      route_dir = mesh_cluster_pkg::DIR_EAST;
    end else if (head_flit_o.dest.node.x < node_x_i) begin
      route_dir = mesh_cluster_pkg::DIR_WEST;
    end else begin
      route_dir = mesh_cluster_pkg::DIR_LOCAL;
    end
  end

  always_comb begin
    head_req_o = '0;
    if (count_q != 2'd0) begin
      head_req_o[route_dir] = 1'b1;
    end
  end

endmodule

//--- hdl/mesh_cluster_pkg.sv
// Mesh cluster shared types
// Port directions, destination encodings and the flit format

`include "mesh_cluster_settings.svh"

package mesh_cluster_pkg;

  // North is increasing y, east is increasing x
  typedef enum logic [2:0] {
    DIR_LOCAL = 3'd0,
    DIR_NORTH = 3'd1,
    DIR_EAST  = 3'd2,
    DIR_SOUTH = 3'd3,
    DIR_WEST  = 3'd4
  } dir_e;

  typedef struct packed {
    logic [`COORD_W-1:0] x;
    logic [`COORD_W-1:0] y;
  } node_dest_t;

  // Side takes the place of x, only bit 0 is meaningful (0 west, 1 east)
  typedef struct packed {
    logic [`COORD_W-1:0] side;
    logic [`COORD_W-1:0] row;
  } edge_dest_t;

  // Row lines up with y in both views
  typedef union packed {
    node_dest_t node;
    edge_dest_t edge_port;
  } dest_u;

  typedef struct packed {
    logic                   is_edge;
    dest_u                  dest;
    logic [`GROUP_ID_W-1:0] src_id;
    logic [`PAYLOAD_W-1:0]  payload;
  } flit_t;

endpackage

//--- include/mesh_cluster_settings.svh
// Mesh cluster settings
// Mesh size, field widths and router port count

`ifndef MESH_CLUSTER_SETTINGS_SVH
`define MESH_CLUSTER_SETTINGS_SVH

// Mesh dimensions
`define MESH_X 2
`define MESH_Y 2

// Field widths
`define COORD_W 1
`define PAYLOAD_W 16
`define GROUP_ID_W 2

// Local plus four neighbours
`define NUM_PORTS 5

`endif
